// ==== logic/mdu_pkg.sv ====
// Widths and constants for the multiply/divide unit; DIV_STEP must divide XLEN evenly.
package mdu_pkg;

    // Operand and result width.
    localparam int XLEN = 32;

    // One operand or result word.
    typedef logic [XLEN-1:0] word_t;

    // Operation code, same encoding as the RISC-V M-extension funct3.
    typedef enum logic [2:0] {
        OP_MUL    = 3'b000,
        OP_MULH   = 3'b001,
        OP_MULHSU = 3'b010,
        OP_MULHU  = 3'b011,
        OP_DIV    = 3'b100,
        OP_DIVU   = 3'b101,
        OP_REM    = 3'b110,
        OP_REMU   = 3'b111
    } mdu_op_e;

    // Request queue depth.
    localparam int FIFO_DEPTH = 4;

    // Read and write pointer into the request queue.
    typedef logic [$clog2(FIFO_DEPTH)-1:0] fifo_ptr_t;

    // Quotient bits resolved per divider clock.
    localparam int DIV_STEP = 4;

    // Divider iterations per operation.
    localparam int DIV_CYCLES = XLEN / DIV_STEP;

    // Divider iteration counter.
    typedef logic [3:0] div_cnt_t;

endpackage

// ==== logic/mdu_issue.sv ====
// Purely combinational; req_ready follows FIFO space only, and operands must be stable with valid.
`timescale 1ns/100ps

module mdu_issue
    import mdu_pkg::*;
(
    input  logic        req_valid,
    output logic        req_ready,
    input  mdu_op_e     req_op,
    input  word_t       req_lhs,
    input  word_t       req_rhs,
    input  logic        full,
    output logic        push,
    output logic        is_div,
    output logic        sel_high_rem,
    output logic [XLEN:0] opa,
    output logic [XLEN:0] opb,
    output logic        neg_result,
    output logic        div_zero,
    output word_t       orig_lhs
);
    // Operand signedness per operation.
    logic  lhs_signed;
    logic  rhs_signed;
    // Operand is signed and negative.
    logic  lhs_neg;
    logic  rhs_neg;
    // Absolute values for the divider.
    word_t lhs_mag;
    word_t rhs_mag;

    // Accept whenever the queue has room.
    assign req_ready = !full;
    assign push      = req_valid && !full;

    // Upper funct3 bit separates divides from multiplies.
    assign is_div = req_op[2];

    always_comb begin
        case (req_op)
            OP_MULH, OP_DIV, OP_REM: begin
                lhs_signed = 1'b1;
                rhs_signed = 1'b1;
            end
            OP_MULHSU: begin
                lhs_signed = 1'b1;
                rhs_signed = 1'b0;
            end
            default: begin
                lhs_signed = 1'b0;
                rhs_signed = 1'b0;
            end
        endcase
    end

    assign lhs_neg = lhs_signed && req_lhs[XLEN-1];
    assign rhs_neg = rhs_signed && req_rhs[XLEN-1];

    // Most negative value maps onto itself, which is the correct unsigned magnitude.
    assign lhs_mag = lhs_neg ? -req_lhs : req_lhs;
    assign rhs_mag = rhs_neg ? -req_rhs : req_rhs;

    // Multiplies get a sign-extended 33-bit operand.
    // Divides get the magnitude with a clear top bit.
    assign opa = is_div ? {1'b0, lhs_mag} : {lhs_neg, req_lhs};
    assign opb = is_div ? {1'b0, rhs_mag} : {rhs_neg, req_rhs};

    // High word for MULH*, remainder for REM*.
    assign sel_high_rem = is_div ? req_op[1] : (req_op[1:0] != 2'b00);

    // Remainder follows the dividend sign.
    // Quotient negated when the signs differ.
    assign neg_result = is_div && (req_op[1] ? lhs_neg : (lhs_neg ^ rhs_neg));

    // Zero divisor is patched after the divider.
    assign div_zero = is_div && (req_rhs == '0);
    assign orig_lhs = req_lhs;

endmodule

// ==== logic/mdu_req_fifo.sv ====
// Push must not happen when full and pop not when empty; read data is valid only while not empty.
`timescale 1ns/100ps

module mdu_req_fifo
    import mdu_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  logic          push,
    output logic          full,
    input  logic          pop,
    output logic          empty,
    input  logic          is_div,
    input  logic          sel_high_rem,
    input  logic [XLEN:0] opa,
    input  logic [XLEN:0] opb,
    input  logic          neg_result,
    input  logic          div_zero,
    input  word_t         orig_lhs,
    output logic          is_div_q,
    output logic          sel_high_rem_q,
    output logic [XLEN:0] opa_q,
    output logic [XLEN:0] opb_q,
    output logic          neg_result_q,
    output logic          div_zero_q,
    output word_t         orig_lhs_q
);
    // Entry storage, one array per field.
    logic          mem_is_div   [FIFO_DEPTH];
    logic          mem_sel_high [FIFO_DEPTH];
    logic [XLEN:0] mem_opa      [FIFO_DEPTH];
    logic [XLEN:0] mem_opb      [FIFO_DEPTH];
    logic          mem_neg      [FIFO_DEPTH];
    logic          mem_zero     [FIFO_DEPTH];
    word_t         mem_lhs      [FIFO_DEPTH];

    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    // Occupancy, one bit wider than a pointer.
    logic [$clog2(FIFO_DEPTH):0] count;

    assign full  = (count == FIFO_DEPTH);
    assign empty = (count == 0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem_is_div[wr_ptr]   <= is_div;
            mem_sel_high[wr_ptr] <= sel_high_rem;
            mem_opa[wr_ptr]      <= opa;
            mem_opb[wr_ptr]      <= opb;
            mem_neg[wr_ptr]      <= neg_result;
            mem_zero[wr_ptr]     <= div_zero;
            mem_lhs[wr_ptr]      <= orig_lhs;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop keeps the count.
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head entry, read combinationally.
    assign is_div_q       = mem_is_div[rd_ptr];
    assign sel_high_rem_q = mem_sel_high[rd_ptr];
    assign opa_q          = mem_opa[rd_ptr];
    assign opb_q          = mem_opb[rd_ptr];
    assign neg_result_q   = mem_neg[rd_ptr];
    assign div_zero_q     = mem_zero[rd_ptr];
    assign orig_lhs_q     = mem_lhs[rd_ptr];

    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n) !(push && full))
        else $error("request FIFO pushed while full");
    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n) !(pop && empty))
        else $error("request FIFO popped while empty");

endmodule

// ==== logic/mdu_div_cyclic.sv ====
// Unsigned only; start must wait until done, and quot/rem are valid only in the done cycle.
`timescale 1ns/100ps

module mdu_div_cyclic
    import mdu_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  start,
    input  word_t dividend,
    input  word_t divisor,
    output logic  done,
    output word_t quot,
    output word_t rem
);
    // Divisor aligned to the current quotient bit, double width.
    logic [2*XLEN-1:0] div_reg;
    // One-hot weight of the current quotient bit.
    word_t             pos_reg;
    // Partial remainder and quotient.
    word_t             rem_reg;
    word_t             quot_reg;
    // Iterations done since start.
    div_cnt_t          cnt;
    logic              busy;
    // Outputs of this cycle's slices.
    word_t             rem_nxt;
    word_t             quot_nxt;

    // DIV_STEP restoring slices, most significant first.
    always_comb begin : slice_chain
        logic [2*XLEN-1:0] div_s;
        word_t             pos_s;
        logic [XLEN:0]     diff;
        logic              ge;
        rem_nxt  = rem_reg;
        quot_nxt = quot_reg;
        for (int j = 0; j < DIV_STEP; j++) begin
            div_s = div_reg >> j;
            pos_s = pos_reg >> j;
            diff  = {1'b0, rem_nxt} - {1'b0, div_s[XLEN-1:0]};
            // Divisor still has bits above the remainder width.
            ge    = !diff[XLEN] && (div_s[2*XLEN-1:XLEN] == '0);
            if (ge) begin
                rem_nxt  = diff[XLEN-1:0];
                quot_nxt = quot_nxt | pos_s;
            end
        end
    end

    // Datapath.
    // A zero divisor always subtracts, giving all ones and the dividend.
    always_ff @(posedge clk) begin
        if (start) begin
            div_reg  <= {{XLEN{1'b0}}, divisor} << (XLEN - 1);
            pos_reg  <= {1'b1, {(XLEN-1){1'b0}}};
            rem_reg  <= dividend;
            quot_reg <= '0;
        end else begin
            div_reg  <= div_reg >> DIV_STEP;
            pos_reg  <= pos_reg >> DIV_STEP;
            rem_reg  <= rem_nxt;
            quot_reg <= quot_nxt;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= '0;
        end else if (busy) begin
            if (done) begin
                busy <= 1'b0;
            end
            cnt <= cnt + 1'b1;
        end
    end

    // Last iteration resolves combinationally in the done cycle.
    assign done = busy && (cnt == div_cnt_t'(DIV_CYCLES - 1));
    assign quot = quot_nxt;
    assign rem  = rem_nxt;

    a_start_idle: assert property (@(posedge clk) disable iff (!arst_n) start |-> !busy)
        else $error("divider started while busy");

endmodule

// ==== logic/mdu_exec.sv ====
// One operation at a time; the result is held until accepted, and nothing pops meanwhile.
`timescale 1ns/100ps

module mdu_exec
    import mdu_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  logic          empty,
    output logic          pop,
    input  logic          is_div_q,
    input  logic          sel_high_rem_q,
    input  logic [XLEN:0] opa_q,
    input  logic [XLEN:0] opb_q,
    input  logic          neg_result_q,
    input  logic          div_zero_q,
    input  word_t         orig_lhs_q,
    output logic          res_valid,
    input  logic          res_ready,
    output word_t         res_data
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DIV,
        ST_HOLD
    } exec_state_e;

    exec_state_e state;

    // Entry fields captured at pop.
    logic              is_div_r;
    logic              sel_high_r;
    logic              neg_result_r;
    logic              div_zero_r;
    word_t             orig_lhs_r;
    // Full signed product of the 33-bit operands.
    logic [2*XLEN+1:0] prod;
    // Corrected divide result.
    word_t             div_res;
    word_t             div_pick;
    word_t             div_fix;

    logic  div_start;
    logic  done;
    word_t quot;
    word_t rem;

    assign pop       = (state == ST_IDLE) && !empty;
    assign div_start = pop && is_div_q;
    assign res_valid = (state == ST_HOLD);

    mdu_div_cyclic u_div (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (div_start),
        .dividend (opa_q[XLEN-1:0]),
        .divisor  (opb_q[XLEN-1:0]),
        .done     (done),
        .quot     (quot),
        .rem      (rem)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (pop) begin
                        state <= is_div_q ? ST_DIV : ST_HOLD;
                    end
                end
                ST_DIV: begin
                    if (done) begin
                        state <= ST_HOLD;
                    end
                end
                ST_HOLD: begin
                    if (res_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Quotient or remainder, sign and zero-divisor fixups.
    assign div_pick = sel_high_r ? rem : quot;
    always_comb begin
        if (div_zero_r) begin
            div_fix = sel_high_r ? orig_lhs_r : '1;
        end else if (neg_result_r) begin
            div_fix = -div_pick;
        end else begin
            div_fix = div_pick;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            is_div_r     <= is_div_q;
            sel_high_r   <= sel_high_rem_q;
            neg_result_r <= neg_result_q;
            div_zero_r   <= div_zero_q;
            orig_lhs_r   <= orig_lhs_q;
            prod         <= $signed(opa_q) * $signed(opb_q);
        end
        if (done) begin
            div_res <= div_fix;
        end
    end

    assign res_data = is_div_r ? div_res :
                      (sel_high_r ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0]);

    a_hold_result: assert property (@(posedge clk) disable iff (!arst_n)
        res_valid && !res_ready |=> res_valid && $stable(res_data))
        else $error("result changed under back-pressure");

endmodule

// ==== logic/mdu_top.sv ====
// Requests must hold steady while valid and not ready; results leave in request order.
`timescale 1ns/100ps

module mdu_top
    import mdu_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    req_valid,
    output logic    req_ready,
    input  mdu_op_e req_op,
    input  word_t   req_lhs,
    input  word_t   req_rhs,
    output logic    res_valid,
    input  logic    res_ready,
    output word_t   res_data
);
    // Queue control.
    logic          push;
    logic          full;
    logic          pop;
    logic          empty;
    // Decoded entry into the queue.
    logic          is_div;
    logic          sel_high_rem;
    logic [XLEN:0] opa;
    logic [XLEN:0] opb;
    logic          neg_result;
    logic          div_zero;
    word_t         orig_lhs;
    // Head entry out of the queue.
    logic          is_div_q;
    logic          sel_high_rem_q;
    logic [XLEN:0] opa_q;
    logic [XLEN:0] opb_q;
    logic          neg_result_q;
    logic          div_zero_q;
    word_t         orig_lhs_q;

    mdu_issue u_issue (
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_op       (req_op),
        .req_lhs      (req_lhs),
        .req_rhs      (req_rhs),
        .full         (full),
        .push         (push),
        .is_div       (is_div),
        .sel_high_rem (sel_high_rem),
        .opa          (opa),
        .opb          (opb),
        .neg_result   (neg_result),
        .div_zero     (div_zero),
        .orig_lhs     (orig_lhs)
    );

    mdu_req_fifo u_fifo (
        .clk            (clk),
        .arst_n         (arst_n),
        .push           (push),
        .full           (full),
        .pop            (pop),
        .empty          (empty),
        .is_div         (is_div),
        .sel_high_rem   (sel_high_rem),
        .opa            (opa),
        .opb            (opb),
        .neg_result     (neg_result),
        .div_zero       (div_zero),
        .orig_lhs       (orig_lhs),
        .is_div_q       (is_div_q),
        .sel_high_rem_q (sel_high_rem_q),
        .opa_q          (opa_q),
        .opb_q          (opb_q),
        .neg_result_q   (neg_result_q),
        .div_zero_q     (div_zero_q),
        .orig_lhs_q     (orig_lhs_q)
    );

    mdu_exec u_exec (
        .clk            (clk),
        .arst_n         (arst_n),
        .empty          (empty),
        .pop            (pop),
        .is_div_q       (is_div_q),
        .sel_high_rem_q (sel_high_rem_q),
        .opa_q          (opa_q),
        .opb_q          (opb_q),
        .neg_result_q   (neg_result_q),
        .div_zero_q     (div_zero_q),
        .orig_lhs_q     (orig_lhs_q),
        .res_valid      (res_valid),
        .res_ready      (res_ready),
        .res_data       (res_data)
    );

endmodule

// ==== test/tb_clock_gen.sv ====
// Free-running 4 ns clock; reset is held low for four rising edges and released 1 ns after the last.
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);
    // Half period of 2 ns.
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Release away from the edge.
    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule

// ==== test/tb_mdu_top.sv ====
// Vectors come from test/mdu_stimulus.txt, run from the project root; at most MAX_VEC vectors.
`timescale 1ns/100ps

module tb_mdu_top
    import mdu_pkg::*;
;
    // Capacity of the vector memory.
    localparam int MAX_VEC = 64;

    logic    clk;
    logic    arst_n;
    logic    req_valid;
    logic    req_ready;
    mdu_op_e req_op;
    word_t   req_lhs;
    word_t   req_rhs;
    logic    res_valid;
    logic    res_ready;
    word_t   res_data;

    // Four words per vector: op, lhs, rhs, expected.
    logic [31:0] vec_mem [0:4*MAX_VEC-1];
    int          num_vec;
    // Vector currently on the request port.
    int          drive_idx;
    // Vector indices accepted but not yet answered.
    int          pending_q[$];
    int          sent_count;
    int          recv_count;
    int          mismatch_count;
    int          other_count;
    // Cycles seen with req_ready low.
    int          full_cycles;

    tb_clock_gen u_clk (
        .clk    (clk),
        .arst_n (arst_n)
    );

    mdu_top i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_op    (req_op),
        .req_lhs   (req_lhs),
        .req_rhs   (req_rhs),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_data  (res_data)
    );

    // Compare one value and log a mismatch.
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Plain failure, not a value compare.
    task automatic report_error(input string text);
        other_count++;
        $display("ERROR: %s", text);
    endtask

    // Hold the request until it is taken on a rising edge.
    // Ready is sampled at the falling edge, where it is stable.
    task automatic wait_accept();
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = req_ready;
            @(posedge clk);
        end
        #1;
    endtask

    task automatic print_counts();
        $display("Summary: %0d of %0d results, %0d mismatches, %0d other errors",
                 recv_count, num_vec, mismatch_count, other_count);
    endtask

    // Random result back-pressure, changed 1 ns after each rising edge.
    initial begin : backpressure
        void'($urandom(78592));
        res_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1 res_ready = ($urandom() % 2) == 0;
        end
    end

    // Handshake monitor, sampled at the falling edge.
    always @(negedge clk) begin
        if (arst_n) begin
            // Ready low means the queue is full.
            if (!req_ready && (sent_count - recv_count) < FIFO_DEPTH) begin
                report_error($sformatf("req_ready low with only %0d requests in flight",
                                       sent_count - recv_count));
            end
            if (!req_ready) begin
                full_cycles++;
            end
            // Four queued plus one executing at most.
            if ((sent_count - recv_count) > FIFO_DEPTH + 1) begin
                report_error($sformatf("%0d requests in flight, more than the unit can hold",
                                       sent_count - recv_count));
            end
            if (res_valid && res_ready) begin
                if (pending_q.size() == 0) begin
                    report_error("result delivered with no request outstanding");
                end else begin
                    check_value($sformatf("vector %0d op %0d", pending_q[0],
                                          vec_mem[4*pending_q[0]][2:0]),
                                vec_mem[4*pending_q[0]+3], res_data);
                    void'(pending_q.pop_front());
                end
                recv_count++;
            end
            if (req_valid && req_ready) begin
                pending_q.push_back(drive_idx);
                sent_count++;
            end
        end
    end

    // Budget of one full queue of divides per vector.
    initial begin : watchdog
        @(posedge arst_n);
        repeat (num_vec * (DIV_CYCLES + 4) * FIFO_DEPTH + 16) @(posedge clk);
        report_error("timeout, results still missing");
        print_counts();
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : main
        req_valid      = 1'b0;
        req_op         = OP_MUL;
        req_lhs        = '0;
        req_rhs        = '0;
        drive_idx      = 0;
        sent_count     = 0;
        recv_count     = 0;
        mismatch_count = 0;
        other_count    = 0;
        full_cycles    = 0;

        $readmemh("test/mdu_stimulus.txt", vec_mem);
        // Vector count ends at the first unloaded expected word.
        num_vec = 0;
        while (num_vec < MAX_VEC && !$isunknown(vec_mem[4*num_vec+3])) begin
            num_vec++;
        end
        if (num_vec == 0) begin
            report_error("no vectors loaded from the stimulus file");
        end

        @(posedge arst_n);
        // Idle after reset.
        repeat (3) begin
            @(negedge clk);
            check_value("reset res_valid", 32'd0, {31'd0, res_valid});
            check_value("reset req_ready", 32'd1, {31'd0, req_ready});
        end
        @(posedge clk);
        #1;

        // Back to back requests.
        for (int i = 0; i < num_vec; i++) begin
            drive_idx = i;
            req_valid = 1'b1;
            req_op    = mdu_op_e'(vec_mem[4*i][2:0]);
            req_lhs   = vec_mem[4*i+1];
            req_rhs   = vec_mem[4*i+2];
            wait_accept();
        end
        req_valid = 1'b0;

        wait (recv_count >= num_vec);
        // No extra result may follow.
        repeat (DIV_CYCLES + 4) begin
            @(negedge clk);
            if (res_valid) begin
                report_error("result valid after all vectors completed");
            end
        end

        if (full_cycles == 0) begin
            report_error("req_ready never fell, so the request FIFO never filled");
        end

        print_counts();
        if (mismatch_count == 0 && other_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== test/mdu_stimulus.txt ====
// Columns: op (funct3: 0 MUL 1 MULH 2 MULHSU 3 MULHU 4 DIV 5 DIVU 6 REM 7 REMU),
// lhs, rhs, expected result; all hex.
0 00000007 00000006 0000002a
0 fffffffd 00000005 fffffff1
0 80000000 ffffffff 80000000
1 80000000 80000000 40000000
1 ffffffff 00000007 ffffffff
2 ffffffff ffffffff ffffffff
2 00000002 ffffffff 00000001
3 ffffffff ffffffff fffffffe
3 80000000 00000004 00000002
4 00000014 00000006 00000003
4 ffffffec 00000006 fffffffd
4 00000014 fffffffa fffffffd
4 ffffffec fffffffa 00000003
6 00000014 00000006 00000002
6 ffffffec 00000006 fffffffe
6 00000014 fffffffa 00000002
6 ffffffec fffffffa fffffffe
5 ffffffff 00000010 0fffffff
7 ffffffff 00000010 0000000f
4 00001234 00000000 ffffffff
6 00001234 00000000 00001234
5 80000000 00000000 ffffffff
7 deadbeef 00000000 deadbeef
4 80000000 ffffffff 80000000
6 80000000 ffffffff 00000000

// ==== sim.f ====
logic/mdu_pkg.sv
logic/mdu_issue.sv
logic/mdu_req_fifo.sv
logic/mdu_div_cyclic.sv
logic/mdu_exec.sv
logic/mdu_top.sv
test/tb_clock_gen.sv
test/tb_mdu_top.sv
